// ==== Bender.yml ====
package:
  name: cache_sys

sources:
  - cache_pkg.sv
  - cache_array.sv
  - cache_ctrl.sv
  - mem_dispatch.sv
  - mem_bank.sv
  - mem_collect.sv
  - cache_sys_top.sv
  - target: test
    files:
      - cache_sys_chk.sv
      - cache_sys_tb.sv

// ==== build.f ====
cache_pkg.sv
cache_array.sv
cache_ctrl.sv
mem_dispatch.sv
mem_bank.sv
mem_collect.sv
cache_sys_top.sv
cache_sys_chk.sv
cache_sys_tb.sv

// ==== cache_array.sv ====
module cache_array (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [cache_pkg::index_w-1:0]                           index,
    input  logic                                                    wr,
    input  logic [1:0]                                              word,
    input  logic [cache_pkg::word_w-1:0]                            wdata,
    input  logic                                                    meta_wr,
    input  cache_pkg::line_meta_t                                   meta_new,
    output cache_pkg::line_meta_t                                   meta,
    output logic [cache_pkg::words_per_line-1:0][cache_pkg::word_w-1:0] line_data
);
    import cache_pkg::*;

    logic [words_per_line-1:0][word_w-1:0] data_mem [lines];
    logic [tag_w-1:0]                      tag_mem  [lines];
    logic [lines-1:0]                      valid_q;
    logic [lines-1:0]                      dirty_q;

    // Combinational read of the addressed line
    assign line_data = data_mem[index];
    assign meta      = '{valid: valid_q[index], dirty: dirty_q[index], tag: tag_mem[index]};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;                   // All lines invalid
        end else if (meta_wr) begin
            valid_q[index] <= meta_new.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (meta_wr) begin
            dirty_q[index] <= meta_new.dirty;
            tag_mem[index] <= meta_new.tag;
        end
        if (wr) begin
            data_mem[index][word] <= wdata;
        end
    end

endmodule

// ==== cache_ctrl.sv ====
module cache_ctrl (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    rd,
    input  logic                                                    wr,
    input  cache_pkg::addr_u                                        addr,
    input  logic [cache_pkg::word_w-1:0]                            wdata,
    output logic                                                    done,
    output logic                                                    cache_hit,
    output logic                                                    stall,
    output logic [cache_pkg::word_w-1:0]                            rdata,
    input  cache_pkg::line_meta_t                                   meta,
    input  logic [cache_pkg::words_per_line-1:0][cache_pkg::word_w-1:0] line_data,
    output logic                                                    arr_wr,
    output logic [1:0]                                              arr_word,
    output logic [cache_pkg::word_w-1:0]                            arr_wdata,
    output logic                                                    meta_wr,
    output cache_pkg::line_meta_t                                   meta_new,
    output cache_pkg::mem_req_t                                     mem_req,
    input  logic [cache_pkg::num_banks-1:0]                         bank_busy,
    input  cache_pkg::mem_rsp_t                                     mem_rsp
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_compare,
        s_writeback,
        s_wb_wait,
        s_fill,
        s_fill_wait,
        s_finish
    } state_t;

    state_t     state;
    state_t     nxt_state;
    logic [1:0] cnt_q;       // Word being sent to memory
    logic [1:0] ret_q;       // Fill words stored so far
    logic       hit;
    logic       issue_ok;
    logic       filling;
    addr_u      wb_addr;
    addr_u      fill_addr;

    assign hit      = meta.valid && (meta.tag == addr.c.tag);
    assign issue_ok = ~bank_busy[cnt_q];    // Word n lives in bank n
    assign filling  = (state == s_fill) || (state == s_fill_wait);
    assign rdata    = line_data[addr.c.word];

    // Victim line address and requested line address
    always_comb begin
        wb_addr             = addr;
        wb_addr.c.tag       = meta.tag;
        wb_addr.c.word      = cnt_q;
        wb_addr.c.byte_off  = 1'b0;
        fill_addr           = addr;
        fill_addr.c.word    = cnt_q;
        fill_addr.c.byte_off = 1'b0;
    end

    always_comb begin
        nxt_state = state;
        case (state)
            s_idle: begin
                if (rd || wr) begin
                    nxt_state = s_compare;
                end
            end
            s_compare: begin
                if (hit) begin
                    nxt_state = s_idle;
                end else if (meta.valid && meta.dirty) begin
                    nxt_state = s_writeback;
                end else begin
                    nxt_state = s_fill;
                end
            end
            s_writeback: begin
                if (issue_ok && cnt_q == 2'd3) begin
                    nxt_state = s_wb_wait;
                end
            end
            s_wb_wait: begin
                if (bank_busy == '0) begin   // All victim writes retired
                    nxt_state = s_fill;
                end
            end
            s_fill: begin
                if (issue_ok && cnt_q == 2'd3) begin
                    nxt_state = s_fill_wait;
                end
            end
            s_fill_wait: begin
                if (mem_rsp.valid && ret_q == 2'd3) begin
                    nxt_state = s_finish;
                end
            end
            default: nxt_state = s_idle;    // s_finish
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            cnt_q <= '0;
            ret_q <= '0;
        end else begin
            state <= nxt_state;
            if ((state == s_writeback || state == s_fill) && issue_ok) begin
                cnt_q <= cnt_q + 2'd1;       // Wraps back to 0 after word 3
            end
            if (state == s_compare) begin
                ret_q <= '0;
            end else if (filling && mem_rsp.valid) begin
                ret_q <= ret_q + 2'd1;
            end
        end
    end

    always_comb begin
        done      = 1'b0;
        cache_hit = 1'b0;
        stall     = 1'b0;
        arr_wr    = 1'b0;
        arr_word  = addr.c.word;
        arr_wdata = wdata;
        meta_wr   = 1'b0;
        meta_new  = '{valid: 1'b1, dirty: wr, tag: addr.c.tag};
        mem_req   = '0;
        case (state)
            s_compare: begin
                done      = hit;
                cache_hit = hit;
                stall     = ~hit;
                arr_wr    = hit & wr;        // Write hit updates word and dirty bit
                meta_wr   = hit & wr;
            end
            s_writeback: begin
                stall         = 1'b1;
                mem_req.wr    = issue_ok;
                mem_req.addr  = wb_addr;
                mem_req.wdata = line_data[cnt_q];
            end
            s_wb_wait: begin
                stall = 1'b1;
            end
            s_fill: begin
                stall        = 1'b1;
                mem_req.rd   = issue_ok;
                mem_req.addr = fill_addr;
            end
            s_fill_wait: begin
                stall = 1'b1;
            end
            s_finish: begin
                done    = 1'b1;
                arr_wr  = wr;                // Merge the write word into the new line
                meta_wr = 1'b1;
            end
            default: begin
            end
        endcase
        if (filling && mem_rsp.valid) begin
            arr_wr    = 1'b1;
            arr_word  = mem_rsp.word;
            arr_wdata = mem_rsp.rdata;
        end
    end

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

    localparam int word_w         = 16;
    localparam int tag_w          = 5;
    localparam int index_w        = 8;
    localparam int lines          = 256;
    localparam int words_per_line = 4;
    localparam int num_banks      = 4;
    localparam int bank_rows      = 8192;
    localparam int mem_latency    = 4;     // Accept to read data valid

    // Address as the cache sees it
    typedef struct packed {
        logic [tag_w-1:0]                  tag;
        logic [index_w-1:0]                index;
        logic [$clog2(words_per_line)-1:0] word;
        logic                              byte_off;   // Ignored
    } cache_addr_t;

    // Address as the interleaved memory sees it
    typedef struct packed {
        logic [$clog2(bank_rows)-1:0] row;
        logic [$clog2(num_banks)-1:0] bank;   // Same bits as word
        logic                         byte_off;
    } mem_addr_t;

    typedef union packed {
        cache_addr_t c;
        mem_addr_t   m;
    } addr_u;

    typedef struct packed {
        logic              rd;
        logic              wr;
        addr_u             addr;
        logic [word_w-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                              valid;
        logic [$clog2(words_per_line)-1:0] word;    // Word of the line being returned
        logic [word_w-1:0]                 rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [tag_w-1:0] tag;
    } line_meta_t;

endpackage

// ==== cache_sys_chk.sv ====
module cache_sys_chk (
    input logic                                           clk,
    input logic                                           rst,
    input logic                                           rd,
    input logic                                           wr,
    input logic                                           done,
    input logic                                           stall,
    input cache_pkg::mem_req_t [cache_pkg::num_banks-1:0] bank_req,
    input logic [cache_pkg::num_banks-1:0]                busy_each,
    input cache_pkg::mem_rsp_t [cache_pkg::num_banks-1:0] bank_rsp
);
    import cache_pkg::*;

    logic [num_banks-1:0] req_act;     // Bank sees rd or wr this cycle
    logic [num_banks-1:0] rsp_valid;
    int                   assert_fails = 0;

    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            req_act[b]   = bank_req[b].rd | bank_req[b].wr;
            rsp_valid[b] = bank_rsp[b].valid;
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            assert_fails++;
            $error("done stayed high for more than one cycle");
        end

    a_busy_issue: assert property (@(posedge clk) disable iff (rst) (req_act & busy_each) == '0)
        else begin
            assert_fails++;
            $error("memory request sent to a busy bank");
        end

    a_one_rsp: assert property (@(posedge clk) disable iff (rst) $onehot0(rsp_valid))
        else begin
            assert_fails++;
            $error("more than one bank response valid in a cycle");
        end

    a_idle_stall: assert property (@(posedge clk) disable iff (rst) !(rd || wr) |-> !stall)
        else begin
            assert_fails++;
            $error("stall high with no request held");
        end

endmodule

bind cache_sys_top cache_sys_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .rd        (rd),
    .wr        (wr),
    .done      (done),
    .stall     (stall),
    .bank_req  (bank_req),
    .busy_each (busy_each),
    .bank_rsp  (bank_rsp)
);

// ==== cache_sys_tb.sv ====
module cache_sys_tb;
    import cache_pkg::*;

    typedef struct packed {
        logic              is_wr;
        logic [15:0]       addr;
        logic [word_w-1:0] wdata;
        logic [word_w-1:0] exp_data;
        logic              exp_hit;
    } test_t;

    logic              clk;
    logic              rst;
    logic              rd;
    logic              wr;
    addr_u             addr;
    logic [word_w-1:0] wdata;
    logic [word_w-1:0] rdata;
    logic              done;
    logic              cache_hit;
    logic              stall;

    test_t tests[$];
    int    pass_cnt;
    int    fail_cnt;
    int    cycles      = 0;
    int    cycle_limit = 0;    // Zero until the tests are loaded

    cache_sys_top uut (
        .clk       (clk),
        .rst       (rst),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .done      (done),
        .cache_hit (cache_hit),
        .stall     (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: no done from the DUT within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic load_tests();
        int                fd;
        int                n;
        logic [7:0]        kind;
        logic [15:0]       a;
        logic [15:0]       d;
        logic [15:0]       e;
        logic [3:0]        h;
        logic [8*128-1:0]  skip_buf;
        fd = $fopen("cache_sys_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open cache_sys_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", kind);
                if (n == 1 && kind == "#") begin
                    n = $fgets(skip_buf, fd);    // Rest of a comment line
                end else if (n == 1) begin
                    n = $fscanf(fd, "%h %h %h %h", a, d, e, h);
                    if (n == 4) begin
                        tests.push_back('{is_wr: (kind == "w"), addr: a, wdata: d,
                                          exp_data: e, exp_hit: h[0]});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int num, input test_t t);
        logic ok;
        logic stall_ok;
        ok       = 1'b1;
        stall_ok = 1'b1;
        @(negedge clk);
        rd    = ~t.is_wr;
        wr    = t.is_wr;
        addr  = t.addr;
        wdata = t.wdata;
        @(negedge clk);
        while (!done) begin
            if (stall_ok && stall !== 1'b1) begin    // Miss in progress
                $display("Mismatch test %0d: stall got 0x%h expected 0x1", num, stall);
                stall_ok = 1'b0;
                ok       = 1'b0;
            end
            @(negedge clk);            // Request held until done
        end
        if (t.exp_hit && stall !== 1'b0) begin
            $display("Mismatch test %0d: stall got 0x%h expected 0x0", num, stall);
            ok = 1'b0;
        end
        if (cache_hit !== t.exp_hit) begin
            $display("Mismatch test %0d: cache_hit got 0x%h expected 0x%h",
                     num, cache_hit, t.exp_hit);
            ok = 1'b0;
        end
        if (!t.is_wr && rdata !== t.exp_data) begin
            $display("Mismatch test %0d: rdata got 0x%h expected 0x%h",
                     num, rdata, t.exp_data);
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("Test %0d %s addr 0x%h: %s", num, t.is_wr ? "write" : "read",
                 t.addr, ok ? "ok" : "error");
        @(negedge clk);
        rd = 1'b0;
        wr = 1'b0;
    endtask

    initial begin
        rst      = 1'b1;
        rd       = 1'b0;
        wr       = 1'b0;
        addr     = '0;
        wdata    = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        load_tests();
        cycle_limit = tests.size() * 40 + 10;    // Plus the reset cycles
        repeat (5) @(negedge clk);
        rst = 1'b0;
        foreach (tests[i]) begin
            run_test(i, tests[i]);
        end
        $display("Tests: %0d passed, %0d failed, %0d assertion failures",
                 pass_cnt, fail_cnt, uut.u_chk.assert_fails);
        if (fail_cnt == 0 && uut.u_chk.assert_fails == 0 && tests.size() > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== cache_sys_tests.txt ====
# kind (r or w), address, write data, expected read data, expected hit (all hex)
# expected read data is not checked for writes
w 0010 1111 0000 0
r 0010 0000 1111 1
w 0012 2222 0000 1
w 0014 3333 0000 1
w 0016 4444 0000 1
r 0012 0000 2222 1
w 0816 5555 0000 0
r 0010 0000 1111 0
r 0014 0000 3333 1
w 0012 6666 0000 1
r 0010 0000 1111 1
r 0014 0000 3333 1
r 0016 0000 4444 1
r 0012 0000 6666 1
r 0816 0000 5555 0
r 0012 0000 6666 0
w 1082 abcd 0000 0
w 1084 0123 0000 1
w 3ffe beef 0000 0
w fff8 cafe 0000 0
r 3ffe 0000 beef 0
r fff8 0000 cafe 0
r 1082 0000 abcd 1
r 1084 0000 0123 1
w 2882 7777 0000 0
r 1082 0000 abcd 0
r 2882 0000 7777 0
w 0400 0f0f 0000 0
w 0402 1e1e 0000 1
w 0404 2d2d 0000 1
w 0406 3c3c 0000 1
r 0406 0000 3c3c 1
w 0400 4b4b 0000 1
r 0400 0000 4b4b 1
w 4c04 5a5a 0000 0
r 0400 0000 4b4b 0
r 0402 0000 1e1e 1
r 4c04 0000 5a5a 0
r 0010 0000 1111 1

// ==== cache_sys_top.sv ====
module cache_sys_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rd,
    input  logic                         wr,
    input  cache_pkg::addr_u             addr,
    input  logic [cache_pkg::word_w-1:0] wdata,
    output logic [cache_pkg::word_w-1:0] rdata,
    output logic                         done,
    output logic                         cache_hit,
    output logic                         stall
);
    import cache_pkg::*;

    line_meta_t                            meta;
    line_meta_t                            meta_new;
    logic [words_per_line-1:0][word_w-1:0] line_data;
    logic                                  arr_wr;
    logic [1:0]                            arr_word;
    logic [word_w-1:0]                     arr_wdata;
    logic                                  meta_wr;
    mem_req_t                              mem_req;
    mem_req_t [num_banks-1:0]              bank_req;
    mem_rsp_t [num_banks-1:0]              bank_rsp;
    mem_rsp_t                              mem_rsp;
    logic [num_banks-1:0]                  busy_each;
    logic [num_banks-1:0]                  bank_busy;

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .wdata     (wdata),
        .done      (done),
        .cache_hit (cache_hit),
        .stall     (stall),
        .rdata     (rdata),
        .meta      (meta),
        .line_data (line_data),
        .arr_wr    (arr_wr),
        .arr_word  (arr_word),
        .arr_wdata (arr_wdata),
        .meta_wr   (meta_wr),
        .meta_new  (meta_new),
        .mem_req   (mem_req),
        .bank_busy (bank_busy),
        .mem_rsp   (mem_rsp)
    );

    cache_array u_array (
        .clk       (clk),
        .rst       (rst),
        .index     (addr.c.index),   // Held request selects the line
        .wr        (arr_wr),
        .word      (arr_word),
        .wdata     (arr_wdata),
        .meta_wr   (meta_wr),
        .meta_new  (meta_new),
        .meta      (meta),
        .line_data (line_data)
    );

    mem_dispatch u_dispatch (
        .req       (mem_req),
        .bank_req  (bank_req),
        .busy_each (busy_each),
        .bank_busy (bank_busy)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        mem_bank u_bank (
            .clk  (clk),
            .rst  (rst),
            .req  (bank_req[b]),
            .busy (busy_each[b]),
            .rsp  (bank_rsp[b])
        );
    end

    mem_collect u_collect (
        .bank_rsp (bank_rsp),
        .rsp      (mem_rsp)
    );

endmodule

// ==== mem_bank.sv ====
module mem_bank (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t req,
    output logic                busy,
    output cache_pkg::mem_rsp_t rsp
);
    import cache_pkg::*;

    logic [word_w-1:0]                 storage [bank_rows];
    logic [$clog2(mem_latency+1)-1:0]  count_q;     // Cycles left in the access
    logic                              rd_pend_q;
    logic [$clog2(bank_rows)-1:0]      row_q;
    logic [$clog2(words_per_line)-1:0] word_q;      // Line word of the pending read
    logic                              rsp_valid_q;
    logic [$clog2(words_per_line)-1:0] rsp_word_q;
    logic [word_w-1:0]                 rsp_data_q;
    logic                              accept;

    assign busy   = (count_q != '0);
    assign accept = (req.rd | req.wr) & ~busy;
    assign rsp    = '{valid: rsp_valid_q, word: rsp_word_q, rdata: rsp_data_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q     <= '0;
            rd_pend_q   <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_pend_q && (count_q == 1);   // Pulse as busy falls
            if (accept) begin
                count_q   <= ($bits(count_q))'(mem_latency);
                rd_pend_q <= req.rd;
            end else if (busy) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            row_q  <= req.addr.m.row;
            word_q <= req.addr.c.word;
        end
        if (accept && req.wr) begin
            storage[req.addr.m.row] <= req.wdata;      // Stored at acceptance
        end
        if (count_q == 1) begin
            rsp_data_q <= storage[row_q];
            rsp_word_q <= word_q;
        end
    end

endmodule

// ==== mem_collect.sv ====
module mem_collect (
    input  cache_pkg::mem_rsp_t [cache_pkg::num_banks-1:0] bank_rsp,
    output cache_pkg::mem_rsp_t                            rsp
);
    import cache_pkg::*;

    // Banks hold stale data when idle, so only valid returns are merged
    always_comb begin
        rsp = '0;
        for (int b = 0; b < num_banks; b++) begin
            if (bank_rsp[b].valid) begin
                rsp = rsp | bank_rsp[b];
            end
        end
    end

endmodule

// ==== mem_dispatch.sv ====
module mem_dispatch (
    input  cache_pkg::mem_req_t                            req,
    output cache_pkg::mem_req_t [cache_pkg::num_banks-1:0] bank_req,
    input  logic [cache_pkg::num_banks-1:0]                busy_each,
    output logic [cache_pkg::num_banks-1:0]                bank_busy
);
    import cache_pkg::*;

    // Only the addressed bank sees rd or wr
    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            bank_req[b] = '0;                // Idle request
            if (req.addr.m.bank == b) begin
                bank_req[b] = req;
            end
        end
    end

    assign bank_busy = busy_each;            // Bit n is bank n

endmodule
